/* common/reg_pkg.sv */
// ----------------------------------------------------------------------
// Register file sizes and tag types for the rename stage.
// Covers the architectural register numbers and physical tags.
// ----------------------------------------------------------------------
package reg_pkg;

  // Architectural and physical register file sizes.
  localparam int num_arch_regs = 32;
  localparam int num_phys_regs = 96;

  // Depth of the free list ring.
  // It holds every tag that is not an identity mapping at reset.
  localparam int num_free_regs = 64;

  // Lowest tag placed in the ring at reset.
  // Tags below this one start out as the identity map.
  localparam int first_free_tag = 32;

  localparam int arch_reg_width = $clog2(num_arch_regs);
  localparam int phys_reg_width = $clog2(num_phys_regs);
  localparam int free_ptr_width = $clog2(num_free_regs);

  typedef logic [arch_reg_width-1:0] arch_reg_t;
  typedef logic [phys_reg_width-1:0] phys_reg_t;

  // Count of free tags needs one extra bit to reach the full ring depth.
  typedef logic [free_ptr_width:0]   free_count_t;
  typedef logic [free_ptr_width-1:0] free_ptr_t;

endpackage

/* common/slot_pkg.sv */
// ----------------------------------------------------------------------
// Instruction word layout, opcodes and dispatch width of the rename stage.
// ----------------------------------------------------------------------
package slot_pkg;

  // Two instructions enter rename per cycle.
  localparam int dispatch_width = 2;
  localparam int inst_width     = 32;

  typedef logic [inst_width-1:0] inst_t;

  // Counts from 0 up to the dispatch width.
  typedef logic [$clog2(dispatch_width+1)-1:0] slot_count_t;

  // Field positions inside an instruction word.
  localparam int opcode_lsb = 0;
  localparam int opcode_msb = 6;
  localparam int rd_lsb     = 7;
  localparam int rd_msb     = 11;
  localparam int rs1_lsb    = 15;
  localparam int rs1_msb    = 19;
  localparam int rs2_lsb    = 20;
  localparam int rs2_msb    = 24;

  typedef logic [opcode_msb-opcode_lsb:0] opcode_t;

  // Major opcodes of the base integer set.
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;

endpackage

/* hdl/rename_decode.sv */
// ----------------------------------------------------------------------
// Rename decode: extracts register fields from two instruction words,
// flags writers, counts tag allocations and finds slot 1 dependencies.
// ----------------------------------------------------------------------
module rename_decode (
  input  slot_pkg::inst_t       inst_0,
  input  slot_pkg::inst_t       inst_1,
  input  slot_pkg::slot_count_t dispatch_count,
  output reg_pkg::arch_reg_t    src1_0,
  output reg_pkg::arch_reg_t    src2_0,
  output reg_pkg::arch_reg_t    dest_0,
  output reg_pkg::arch_reg_t    src1_1,
  output reg_pkg::arch_reg_t    src2_1,
  output reg_pkg::arch_reg_t    dest_1,
  output logic                  writes_0,
  output logic                  writes_1,
  output slot_pkg::slot_count_t alloc_count,
  output logic                  dep_src1_1,
  output logic                  dep_src2_1
);
  import reg_pkg::*;
  import slot_pkg::*;

  opcode_t   opcode_0;
  opcode_t   opcode_1;
  arch_reg_t rd_0;
  arch_reg_t rd_1;
  logic      valid_0;
  logic      valid_1;

  // Opcodes that produce a register result.
  function automatic logic op_writes_rd(input opcode_t opcode);
    case (opcode)
      op_lui, op_auipc, op_jal, op_jalr, op_load, op_imm, op_reg: op_writes_rd = 1'b1;
      default: op_writes_rd = 1'b0;
    endcase
  endfunction

  // Everything except the upper-immediate forms and jal reads rs1.
  function automatic logic op_reads_rs1(input opcode_t opcode);
    op_reads_rs1 = !(opcode inside {op_lui, op_auipc, op_jal});
  endfunction

  // Only compares, stores and register-register ops read rs2.
  function automatic logic op_reads_rs2(input opcode_t opcode);
    op_reads_rs2 = opcode inside {op_branch, op_store, op_reg};
  endfunction

  assign opcode_0 = inst_0[opcode_msb:opcode_lsb];
  assign opcode_1 = inst_1[opcode_msb:opcode_lsb];
  assign rd_0     = inst_0[rd_msb:rd_lsb];
  assign rd_1     = inst_1[rd_msb:rd_lsb];

  // Slots fill from slot 0, so slot 1 is valid only for a full group.
  assign valid_0 = dispatch_count != '0;
  assign valid_1 = dispatch_count > slot_count_t'(1);

  // Sources that the opcode does not read are steered to register 0.
  // Register 0 always maps to tag 0, so the tag output follows.
  assign src1_0 = op_reads_rs1(opcode_0) ? inst_0[rs1_msb:rs1_lsb] : '0;
  assign src2_0 = op_reads_rs2(opcode_0) ? inst_0[rs2_msb:rs2_lsb] : '0;
  assign src1_1 = op_reads_rs1(opcode_1) ? inst_1[rs1_msb:rs1_lsb] : '0;
  assign src2_1 = op_reads_rs2(opcode_1) ? inst_1[rs2_msb:rs2_lsb] : '0;
  assign dest_0 = rd_0;
  assign dest_1 = rd_1;

  // A write to register 0 is discarded and takes no tag.
  assign writes_0 = valid_0 && op_writes_rd(opcode_0) && (rd_0 != '0);
  assign writes_1 = valid_1 && op_writes_rd(opcode_1) && (rd_1 != '0);

  assign alloc_count = slot_count_t'(writes_0) + slot_count_t'(writes_1);

  // A slot 1 source that names slot 0's destination must see the new tag.
  // Since writes_0 implies dest_0 is nonzero, a forced source never matches.
  assign dep_src1_1 = writes_0 && (src1_1 == dest_0);
  assign dep_src2_1 = writes_0 && (src2_1 == dest_0);

endmodule

/* rename/free_list.sv */
// ----------------------------------------------------------------------
// Free list: ring of free physical tags, two allocations from the head
// and two frees into the tail per cycle.
// ----------------------------------------------------------------------
module free_list (
  input  logic                  clock,
  input  logic                  reset,
  input  slot_pkg::slot_count_t alloc_count,
  input  logic                  alloc_enable,
  input  logic                  free_valid_0,
  input  logic                  free_valid_1,
  input  reg_pkg::phys_reg_t    free_tag_0,
  input  reg_pkg::phys_reg_t    free_tag_1,
  output reg_pkg::phys_reg_t    alloc_tag_0,
  output reg_pkg::phys_reg_t    alloc_tag_1,
  output reg_pkg::free_count_t  free_count
);
  import reg_pkg::*;

  // Ring storage.
  // Tags leave at the head and come back at the tail, so a freed tag
  // is handed out again only after every older free tag.
  phys_reg_t   ring [num_free_regs];
  free_ptr_t   head;
  free_ptr_t   tail;
  free_count_t count;

  free_ptr_t   head_next_slot;
  free_ptr_t   tail_next_slot;
  free_count_t num_alloc;
  free_count_t num_free;

  // The pointers are exactly as wide as the ring, so adding wraps them.
  assign head_next_slot = head + free_ptr_t'(1);
  assign tail_next_slot = tail + free_ptr_t'(free_valid_0);

  // The two oldest free tags are always offered.
  // The top only accepts a group when enough of them are valid.
  assign alloc_tag_0 = ring[head];
  assign alloc_tag_1 = ring[head_next_slot];

  assign num_alloc = alloc_enable ? free_count_t'(alloc_count) : '0;
  assign num_free  = free_count_t'(free_valid_0) + free_count_t'(free_valid_1);

  assign free_count = count;

  always_ff @(posedge clock) begin
    if (reset) begin
      // Full ring with tags in ascending order.
      // Head equals tail here, and the count tells full from empty.
      for (int i = 0; i < num_free_regs; i++) begin
        ring[i] <= phys_reg_t'(first_free_tag + i);
      end
      head  <= '0;
      tail  <= '0;
      count <= free_count_t'(num_free_regs);
    end else begin
      // Slot 0 is pushed first, so slot 1 lands just behind it.
      if (free_valid_0) begin
        ring[tail] <= free_tag_0;
      end
      if (free_valid_1) begin
        ring[tail_next_slot] <= free_tag_1;
      end

      // Allocation and release move different pointers and can overlap.
      head  <= head + free_ptr_t'(num_alloc);
      tail  <= tail + free_ptr_t'(num_free);
      count <= count + num_free - num_alloc;
    end
  end

  // Entries freed this cycle become visible at the head only after the
  // edge, so there is no path from the retire inputs to alloc_tag.
  // Tags are conserved across the map tables and the ring, which keeps
  // the count within the ring depth.

endmodule

/* rename/map_table.sv */
// ----------------------------------------------------------------------
// Speculative map table: looks up four source tags, forwards slot 0's
// new tag to slot 1, and records the two new destination mappings.
// ----------------------------------------------------------------------
module map_table (
  input  logic               clock,
  input  logic               reset,
  input  reg_pkg::arch_reg_t src1_0,
  input  reg_pkg::arch_reg_t src2_0,
  input  reg_pkg::arch_reg_t dest_0,
  input  reg_pkg::arch_reg_t src1_1,
  input  reg_pkg::arch_reg_t src2_1,
  input  reg_pkg::arch_reg_t dest_1,
  input  logic               writes_0,
  input  logic               writes_1,
  input  logic               dep_src1_1,
  input  logic               dep_src2_1,
  input  logic               accept,
  input  reg_pkg::phys_reg_t alloc_tag_0,
  input  reg_pkg::phys_reg_t alloc_tag_1,
  output reg_pkg::phys_reg_t src1_tag_0,
  output reg_pkg::phys_reg_t src2_tag_0,
  output reg_pkg::phys_reg_t src1_tag_1,
  output reg_pkg::phys_reg_t src2_tag_1,
  output reg_pkg::phys_reg_t dest_tag_0,
  output reg_pkg::phys_reg_t dest_tag_1
);
  import reg_pkg::*;

  // One physical tag per architectural register.
  phys_reg_t map [num_arch_regs];

  phys_reg_t new_tag_0;
  phys_reg_t new_tag_1;

  // Tags are taken from the free list in order.
  // If slot 0 takes none, slot 1 gets the head entry.
  assign new_tag_0 = alloc_tag_0;
  assign new_tag_1 = writes_0 ? alloc_tag_1 : alloc_tag_0;

  assign dest_tag_0 = writes_0 ? new_tag_0 : '0;
  assign dest_tag_1 = writes_1 ? new_tag_1 : '0;

  // Slot 0 reads the table as it stands.
  assign src1_tag_0 = map[src1_0];
  assign src2_tag_0 = map[src2_0];

  // Slot 1 sees slot 0's result, which is not in the table yet.
  assign src1_tag_1 = dep_src1_1 ? new_tag_0 : map[src1_1];
  assign src2_tag_1 = dep_src2_1 ? new_tag_0 : map[src2_1];

  always_ff @(posedge clock) begin
    if (reset) begin
      // Identity map, so register 0 holds tag 0 from here on.
      for (int i = 0; i < num_arch_regs; i++) begin
        map[i] <= phys_reg_t'(i);
      end
    end else if (accept) begin
      if (writes_0) begin
        map[dest_0] <= new_tag_0;
      end
      // Slot 1 is younger and overrides slot 0 on the same register.
      if (writes_1) begin
        map[dest_1] <= new_tag_1;
      end
    end
  end

endmodule

/* hdl/retire_map.sv */
// ----------------------------------------------------------------------
// Retirement map: committed register mapping, updated at retire, which
// hands the displaced tags back to the free list.
// ----------------------------------------------------------------------
module retire_map (
  input  logic                  clock,
  input  logic                  reset,
  input  slot_pkg::slot_count_t retire_count,
  input  reg_pkg::arch_reg_t    retire_arch_0,
  input  reg_pkg::arch_reg_t    retire_arch_1,
  input  reg_pkg::phys_reg_t    retire_tag_0,
  input  reg_pkg::phys_reg_t    retire_tag_1,
  output logic                  free_valid_0,
  output logic                  free_valid_1,
  output reg_pkg::phys_reg_t    free_tag_0,
  output reg_pkg::phys_reg_t    free_tag_1
);
  import reg_pkg::*;

  phys_reg_t committed [num_arch_regs];
  logic      same_arch;

  // Retirement is in order from slot 0.
  // The ROB sends only instructions that wrote a nonzero register.
  assign free_valid_0 = retire_count != '0;
  assign free_valid_1 = retire_count > 2'd1;

  // Two retires to one register in a group.
  // Slot 0's tag is committed and displaced in the same cycle.
  assign same_arch = free_valid_0 && (retire_arch_1 == retire_arch_0);

  assign free_tag_0 = committed[retire_arch_0];
  assign free_tag_1 = same_arch ? retire_tag_0 : committed[retire_arch_1];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_arch_regs; i++) begin
        committed[i] <= phys_reg_t'(i);
      end
    end else begin
      if (free_valid_0) begin
        committed[retire_arch_0] <= retire_tag_0;
      end
      // Later statement wins, leaving slot 1's tag committed.
      if (free_valid_1) begin
        committed[retire_arch_1] <= retire_tag_1;
      end
    end
  end

endmodule

/* hdl/rename_top.sv */
// ----------------------------------------------------------------------
// Rename stage top level: decode, free list, speculative map and
// retirement map, with the dispatch stall.
// ----------------------------------------------------------------------
module rename_top (
  input  logic                  clock,
  input  logic                  reset,
  input  slot_pkg::slot_count_t dispatch_count,
  input  slot_pkg::inst_t       dispatch_inst_0,
  input  slot_pkg::inst_t       dispatch_inst_1,
  output logic                  stall,
  output reg_pkg::phys_reg_t    src1_tag_0,
  output reg_pkg::phys_reg_t    src2_tag_0,
  output reg_pkg::phys_reg_t    dest_tag_0,
  output reg_pkg::phys_reg_t    src1_tag_1,
  output reg_pkg::phys_reg_t    src2_tag_1,
  output reg_pkg::phys_reg_t    dest_tag_1,
  output reg_pkg::free_count_t  free_count,
  input  slot_pkg::slot_count_t retire_count,
  input  reg_pkg::arch_reg_t    retire_arch_0,
  input  reg_pkg::arch_reg_t    retire_arch_1,
  input  reg_pkg::phys_reg_t    retire_tag_0,
  input  reg_pkg::phys_reg_t    retire_tag_1
);
  import reg_pkg::*;
  import slot_pkg::*;

  arch_reg_t   src1_0, src2_0, dest_0;
  arch_reg_t   src1_1, src2_1, dest_1;
  logic        writes_0, writes_1;
  logic        dep_src1_1, dep_src2_1;
  slot_count_t alloc_count;
  phys_reg_t   alloc_tag_0, alloc_tag_1;
  logic        free_valid_0, free_valid_1;
  phys_reg_t   free_tag_0, free_tag_1;
  logic        accept;

  // Hold the group while the ring has fewer tags than it needs.
  // Tags freed this cycle do not count until the next edge.
  assign stall  = free_count_t'(alloc_count) > free_count;
  assign accept = (dispatch_count != '0) && !stall;

  rename_decode i_decode (
    .inst_0         (dispatch_inst_0),
    .inst_1         (dispatch_inst_1),
    .dispatch_count (dispatch_count),
    .src1_0         (src1_0),
    .src2_0         (src2_0),
    .dest_0         (dest_0),
    .src1_1         (src1_1),
    .src2_1         (src2_1),
    .dest_1         (dest_1),
    .writes_0       (writes_0),
    .writes_1       (writes_1),
    .alloc_count    (alloc_count),
    .dep_src1_1     (dep_src1_1),
    .dep_src2_1     (dep_src2_1)
  );

  free_list i_free_list (
    .clock        (clock),
    .reset        (reset),
    .alloc_count  (alloc_count),
    .alloc_enable (accept),
    .free_valid_0 (free_valid_0),
    .free_valid_1 (free_valid_1),
    .free_tag_0   (free_tag_0),
    .free_tag_1   (free_tag_1),
    .alloc_tag_0  (alloc_tag_0),
    .alloc_tag_1  (alloc_tag_1),
    .free_count   (free_count)
  );

  map_table i_map_table (
    .clock       (clock),
    .reset       (reset),
    .src1_0      (src1_0),
    .src2_0      (src2_0),
    .dest_0      (dest_0),
    .src1_1      (src1_1),
    .src2_1      (src2_1),
    .dest_1      (dest_1),
    .writes_0    (writes_0),
    .writes_1    (writes_1),
    .dep_src1_1  (dep_src1_1),
    .dep_src2_1  (dep_src2_1),
    .accept      (accept),
    .alloc_tag_0 (alloc_tag_0),
    .alloc_tag_1 (alloc_tag_1),
    .src1_tag_0  (src1_tag_0),
    .src2_tag_0  (src2_tag_0),
    .src1_tag_1  (src1_tag_1),
    .src2_tag_1  (src2_tag_1),
    .dest_tag_0  (dest_tag_0),
    .dest_tag_1  (dest_tag_1)
  );

  retire_map i_retire_map (
    .clock         (clock),
    .reset         (reset),
    .retire_count  (retire_count),
    .retire_arch_0 (retire_arch_0),
    .retire_arch_1 (retire_arch_1),
    .retire_tag_0  (retire_tag_0),
    .retire_tag_1  (retire_tag_1),
    .free_valid_0  (free_valid_0),
    .free_valid_1  (free_valid_1),
    .free_tag_0    (free_tag_0),
    .free_tag_1    (free_tag_1)
  );

endmodule

/* verif/rename_tb.sv */
// ----------------------------------------------------------------------
// Rename stage testbench: seeded random dispatch and in-order retire,
// checked against a reference map, committed map and free queue.
// ----------------------------------------------------------------------
module rename_tb;
  import reg_pkg::*;
  import slot_pkg::*;

  localparam int num_cycles     = 2000;
  localparam int timeout_cycles = num_cycles + num_cycles / 4;
  localparam int clock_period   = 40;
  localparam int drive_delay    = 2;
  localparam int unsigned random_seed = 32'he520_8dbe;

  logic        clock, reset, stall;
  slot_count_t dispatch_count, retire_count;
  inst_t       dispatch_inst_0, dispatch_inst_1;
  phys_reg_t   src1_tag_0, src2_tag_0, dest_tag_0, src1_tag_1, src2_tag_1, dest_tag_1;
  phys_reg_t   retire_tag_0, retire_tag_1;
  arch_reg_t   retire_arch_0, retire_arch_1;
  free_count_t free_count;

  // Reference state holds the speculative map, committed map, free queue and ROB.
  int spec_map [num_arch_regs];
  int committed_map [num_arch_regs];
  int free_q [$];
  int rob_arch [$];
  int rob_tag [$];

  // Prediction for the group on the inputs.
  // A destination of 0 means none.
  logic exp_accept, hold_group;
  int   new_dest_0, new_dest_1, new_tag_0, new_tag_1;
  int   retire_rate, error_count, check_count, cycle_count;

  rename_top i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // The watchdog counts every cycle of the run including the reset cycles.
  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string what, input int got, input int expected);
    check_count++;
    if (got != expected) begin
      error_count++;
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  // Decode rules of the base integer opcodes.
  function automatic logic writes_rd(input opcode_t op);
    return op inside {op_lui, op_auipc, op_jal, op_jalr, op_load, op_imm, op_reg};
  endfunction

  function automatic logic reads_rs1(input opcode_t op);
    return op inside {op_jalr, op_branch, op_load, op_store, op_imm, op_reg};
  endfunction

  function automatic logic reads_rs2(input opcode_t op);
    return op inside {op_branch, op_store, op_reg};
  endfunction

  // Registers 1 to 3 come up often, so slots collide on purpose.
  function automatic arch_reg_t pick_reg();
    int choice;
    choice = $urandom_range(0, 9);
    if (choice == 0) return '0;
    if (choice < 6) return arch_reg_t'($urandom_range(1, 3));
    return arch_reg_t'($urandom_range(0, 31));
  endfunction

  function automatic inst_t random_inst();
    opcode_t opcodes [9];
    inst_t   word;
    opcodes = '{op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load, op_store, op_imm, op_reg};
    word = $urandom();
    word[opcode_msb:opcode_lsb] = opcodes[$urandom_range(0, 8)];
    word[rd_msb:rd_lsb] = pick_reg();
    word[rs1_msb:rs1_lsb] = pick_reg();
    word[rs2_msb:rs2_lsb] = pick_reg();
    return word;
  endfunction

  // A stalled group is held. Retires come from the front of the ROB queue.
  task automatic drive_inputs();
    int n;
    if (!hold_group) begin
      n = $urandom_range(0, 7);
      dispatch_count = slot_count_t'((n == 0) ? 0 : ((n < 3) ? 1 : 2));
      dispatch_inst_0 = random_inst();
      dispatch_inst_1 = random_inst();
    end
    n = 0;
    if (rob_arch.size() > 0 && $urandom_range(0, 3) < retire_rate) n = 1;
    if (n == 1 && rob_arch.size() > 1 && $urandom_range(0, 3) < retire_rate) n = 2;
    retire_count = slot_count_t'(n);
    retire_arch_0 = (n > 0) ? arch_reg_t'(rob_arch[0]) : '0;
    retire_tag_0 = (n > 0) ? phys_reg_t'(rob_tag[0]) : '0;
    retire_arch_1 = (n > 1) ? arch_reg_t'(rob_arch[1]) : '0;
    retire_tag_1 = (n > 1) ? phys_reg_t'(rob_tag[1]) : '0;
  endtask

  // Predicts the response to the current group and compares it.
  // The slots are renamed one after the other on a copy of the map.
  task automatic check_group();
    opcode_t op0, op1;
    int      rd0, rd1, s10, s20, s11, s21, needed, next_free;
    logic    w0, w1;
    int      group_map [num_arch_regs];
    op0 = dispatch_inst_0[opcode_msb:opcode_lsb];
    op1 = dispatch_inst_1[opcode_msb:opcode_lsb];
    rd0 = int'(dispatch_inst_0[rd_msb:rd_lsb]);
    rd1 = int'(dispatch_inst_1[rd_msb:rd_lsb]);
    s10 = reads_rs1(op0) ? int'(dispatch_inst_0[rs1_msb:rs1_lsb]) : 0;
    s20 = reads_rs2(op0) ? int'(dispatch_inst_0[rs2_msb:rs2_lsb]) : 0;
    s11 = reads_rs1(op1) ? int'(dispatch_inst_1[rs1_msb:rs1_lsb]) : 0;
    s21 = reads_rs2(op1) ? int'(dispatch_inst_1[rs2_msb:rs2_lsb]) : 0;
    w0 = (dispatch_count != '0) && writes_rd(op0) && (rd0 != 0);
    w1 = (dispatch_count == 2'd2) && writes_rd(op1) && (rd1 != 0);
    needed = int'(w0) + int'(w1);
    check_value("free_count", int'(free_count), free_q.size());
    check_value("stall", int'(stall), int'(needed > free_q.size()));
    exp_accept = (dispatch_count != '0) && (needed <= free_q.size());
    new_dest_0 = w0 ? rd0 : 0;
    new_dest_1 = w1 ? rd1 : 0;
    new_tag_0 = 0;
    new_tag_1 = 0;
    if (exp_accept) begin
      group_map = spec_map;
      next_free = 0;
      check_value("src1_tag_0", int'(src1_tag_0), group_map[s10]);
      check_value("src2_tag_0", int'(src2_tag_0), group_map[s20]);
      // Each writing slot takes the next tag off the queue front.
      if (w0) begin
        new_tag_0 = free_q[next_free];
        next_free++;
        group_map[rd0] = new_tag_0;
      end
      check_value("dest_tag_0", int'(dest_tag_0), new_tag_0);
      if (dispatch_count == 2'd2) begin
        // Slot 1 reads the map as slot 0 left it.
        if (w1) new_tag_1 = free_q[next_free];
        check_value("src1_tag_1", int'(src1_tag_1), group_map[s11]);
        check_value("src2_tag_1", int'(src2_tag_1), group_map[s21]);
        check_value("dest_tag_1", int'(dest_tag_1), new_tag_1);
      end
    end
  endtask

  // At the clock edge retire frees the old committed tag and then the group commits.
  task automatic update_model();
    int arch;
    for (int i = 0; i < int'(retire_count); i++) begin
      arch = rob_arch.pop_front();
      free_q.push_back(committed_map[arch]);
      committed_map[arch] = rob_tag.pop_front();
    end
    if (exp_accept && new_dest_0 != 0) begin
      void'(free_q.pop_front());
      spec_map[new_dest_0] = new_tag_0;
      rob_arch.push_back(new_dest_0);
      rob_tag.push_back(new_tag_0);
    end
    if (exp_accept && new_dest_1 != 0) begin
      void'(free_q.pop_front());
      spec_map[new_dest_1] = new_tag_1;
      rob_arch.push_back(new_dest_1);
      rob_tag.push_back(new_tag_1);
    end
    hold_group = !exp_accept && (dispatch_count != '0);
  endtask

  initial begin
    void'($urandom(random_seed));
    reset = 1'b1;
    dispatch_count = '0;
    dispatch_inst_0 = '0;
    dispatch_inst_1 = '0;
    retire_count = '0;
    retire_arch_0 = '0;
    retire_arch_1 = '0;
    retire_tag_0 = '0;
    retire_tag_1 = '0;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    retire_rate = 2;
    hold_group = 1'b0;
    exp_accept = 1'b0;
    // Identity maps, and the free queue holds 32 to 95 in order.
    for (int r = 0; r < num_arch_regs; r++) begin
      spec_map[r] = r;
      committed_map[r] = r;
    end
    for (int t = first_free_tag; t < num_phys_regs; t++) free_q.push_back(t);
    repeat (3) @(posedge clock);
    #(drive_delay);
    reset = 1'b0;
    // The first group arrives straight out of reset and needs two tags.
    // It writes r1 and r2, and slot 1 reads r1 from slot 0.
    dispatch_count = 2'd2;
    dispatch_inst_0 = {7'd0, 5'd4, 5'd3, 3'd0, 5'd1, op_reg};
    dispatch_inst_1 = {7'd0, 5'd5, 5'd1, 3'd0, 5'd2, op_reg};
    hold_group = 1'b1;
    for (int cycle = 0; cycle < num_cycles; cycle++) begin
      if (cycle % 100 == 0) retire_rate = $urandom_range(0, 4);
      drive_inputs();
      @(negedge clock);
      check_group();
      @(posedge clock);
      update_model();
      #(drive_delay);
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
common/reg_pkg.sv
common/slot_pkg.sv
hdl/rename_decode.sv
rename/free_list.sv
rename/map_table.sv
hdl/retire_map.sv
hdl/rename_top.sv
verif/rename_tb.sv

/* Makefile */
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing
LINT_FLAGS = --lint-only --timing
TOP        = rename_tb
FILE_LIST  = tb.f
OBJ_DIR    = obj_dir
PASS_TEXT  = STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# Build and run, then search the output for the pass message.
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
